// ==== rtl/bridge_macros.svh ====
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// baud tick every PRESCALE+1 clocks
// 19.2k baud from a 16 MHz clock
`define BRIDGE_PRESCALE 51

// oversampling ticks per serial bit
`define BRIDGE_OVERSAMPLE 16

// command bytes from the host
`define BRIDGE_CMD_RD 8'hA5 // read one word
`define BRIDGE_CMD_WR 8'hA3 // write one word

// address and data go over the wire as this many bytes, lsb first
`define BRIDGE_WORD_BYTES 4

`endif // BRIDGE_MACROS_SVH

// ==== rtl/uart_pkg.sv ====
package uart_pkg;

  // one 8N1 data byte
  typedef logic [7:0] uart_byte_t;

  // counts oversampling ticks inside one bit
  typedef logic [3:0] os_cnt_t;

  // index of the data bit being shifted
  typedef logic [2:0] bit_cnt_t;

  // line state, shared by rx and tx
  typedef enum logic [1:0] {
    UART_IDLE  = 2'b00, // line high, waiting
    UART_START = 2'b01,
    UART_DATA  = 2'b11,
    UART_STOP  = 2'b10
  } uart_state_e;

endpackage

// ==== rtl/ahb_pkg.sv ====
package ahb_pkg;

  typedef logic [31:0] ahb_addr_t;
  typedef logic [31:0] ahb_data_t;
  typedef logic [1:0]  ahb_trans_t; // HTRANS
  typedef logic [2:0]  ahb_size_t;  // HSIZE
  typedef logic [1:0]  byte_idx_t;  // byte lane within a word

  localparam ahb_trans_t HTRANS_IDLE   = 2'b00;
  localparam ahb_trans_t HTRANS_NONSEQ = 2'b10;
  localparam ahb_size_t  HSIZE_WORD    = 3'b010; // 32-bit access

  // request from the command sequencer to the master
  typedef struct packed {
    logic      start; // one-cycle pulse
    logic      write; // 1 write, 0 read
    ahb_addr_t addr;
    ahb_data_t wdata;
  } bus_req_t;

  // everything the master drives onto the bus
  typedef struct packed {
    ahb_addr_t  haddr;
    ahb_trans_t htrans;
    logic       hwrite;
    ahb_size_t  hsize;
    ahb_data_t  hwdata;
  } ahb_mout_t;

endpackage

// ==== rtl/baud_gen.sv ====
`timescale 1ns/1ps
`include "bridge_macros.svh"

module baud_gen #(
  parameter int PRESCALE = `BRIDGE_PRESCALE
) (
  input  logic HCLK,
  input  logic HRESETn,
  output logic tick // one pulse per oversampling period
);

  localparam int CW = (PRESCALE > 0) ? $clog2(PRESCALE + 1) : 1;

  logic [CW-1:0] cnt;

  assign tick = (cnt == CW'(PRESCALE)); // wrap point

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      cnt <= '0;
    end else if (tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // with PRESCALE 0 the tick is simply always high
  if (PRESCALE >= 1) begin : g_tick_chk
    a_tick_single : assert property (@(posedge HCLK) disable iff (!HRESETn) tick |=> !tick);
  end

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps
`include "bridge_macros.svh"

module uart_rx import uart_pkg::*; (
  input  logic       HCLK,
  input  logic       HRESETn,
  input  logic       tick,    // oversampling tick
  input  logic       rx,      // async serial line
  output uart_byte_t rx_byte,
  output logic       rx_done  // one cycle, rx_byte valid
);

  localparam os_cnt_t OS_HALF = os_cnt_t'(`BRIDGE_OVERSAMPLE / 2 - 1);
  localparam os_cnt_t OS_LAST = os_cnt_t'(`BRIDGE_OVERSAMPLE - 1);

  uart_state_e state;
  os_cnt_t     os_cnt;
  bit_cnt_t    bit_cnt;
  uart_byte_t  shift_q;
  logic        rx_meta, rx_s; // two-flop synchroniser
  logic        bit_end;

  assign bit_end = tick && (os_cnt == OS_LAST);
  assign rx_byte = shift_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      rx_meta <= 1'b1; // idle line is high
      rx_s    <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_s    <= rx_meta;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state   <= UART_IDLE;
      os_cnt  <= '0;
      bit_cnt <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (state == UART_IDLE) os_cnt <= '0;
      else if (tick) os_cnt <= (os_cnt == OS_LAST) ? '0 : os_cnt + 1'b1;
      case (state)
        UART_IDLE:  if (!rx_s) state <= UART_START; // falling edge
        UART_START: if (tick && os_cnt == OS_HALF) begin // middle of start bit
          os_cnt  <= '0; // realign to bit centres
          bit_cnt <= '0;
          state   <= rx_s ? UART_IDLE : UART_DATA; // glitch, back to idle
        end
        UART_DATA:  if (bit_end) begin
          if (bit_cnt == 3'd7) state <= UART_STOP;
          bit_cnt <= bit_cnt + 1'b1;
        end
        UART_STOP:  if (bit_end) begin // centre of stop bit
          state   <= UART_IDLE;
          rx_done <= 1'b1;
        end
        default:    state <= UART_IDLE;
      endcase
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge HCLK) begin
    if (state == UART_DATA && bit_end) shift_q <= {rx_s, shift_q[7:1]};
  end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps
`include "bridge_macros.svh"

module uart_tx import uart_pkg::*; (
  input  logic       HCLK,
  input  logic       HRESETn,
  input  logic       tick,     // oversampling tick
  input  logic       tx_start, // one cycle, tx_byte valid
  input  uart_byte_t tx_byte,
  output logic       tx_done,  // end of stop bit
  output logic       tx        // registered serial out
);

  localparam os_cnt_t OS_LAST = os_cnt_t'(`BRIDGE_OVERSAMPLE - 1);

  uart_state_e state;
  os_cnt_t     os_cnt;
  bit_cnt_t    bit_cnt;
  uart_byte_t  shift_q;
  logic        bit_end;

  assign bit_end = tick && (os_cnt == OS_LAST);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state   <= UART_IDLE;
      os_cnt  <= '0;
      bit_cnt <= '0;
      tx_done <= 1'b0;
      tx      <= 1'b1; // line idles high
    end else begin
      tx_done <= 1'b0;
      if (state == UART_IDLE) os_cnt <= '0;
      else if (tick) os_cnt <= (os_cnt == OS_LAST) ? '0 : os_cnt + 1'b1;
      case (state)
        UART_IDLE:  if (tx_start) begin
          state <= UART_START;
          tx    <= 1'b0; // start bit from the next cycle
        end
        UART_START: if (bit_end) begin
          state   <= UART_DATA;
          bit_cnt <= '0;
          tx      <= shift_q[0];
        end
        UART_DATA:  if (bit_end) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) begin
            state <= UART_STOP;
            tx    <= 1'b1; // stop bit
          end else begin
            tx <= shift_q[1]; // next bit, before the shift lands
          end
        end
        UART_STOP:  if (bit_end) begin
          state   <= UART_IDLE;
          tx_done <= 1'b1;
        end
        default:    state <= UART_IDLE;
      endcase
    end
  end

  // byte is loaded once and shifted right per bit
  always_ff @(posedge HCLK) begin
    if (state == UART_IDLE && tx_start) shift_q <= tx_byte;
    else if (state == UART_DATA && bit_end) shift_q <= shift_q >> 1;
  end

  // sequencer has to wait for tx_done before the next byte
  a_start_idle : assert property (@(posedge HCLK) disable iff (!HRESETn)
    tx_start |-> state == UART_IDLE);

endmodule

// ==== rtl/cmd_seq.sv ====
`timescale 1ns/1ps
`include "bridge_macros.svh"

module cmd_seq import uart_pkg::*, ahb_pkg::*; (
  input  logic       HCLK,
  input  logic       HRESETn,
  input  uart_byte_t rx_byte,
  input  logic       rx_done,
  output bus_req_t   req,
  input  logic       done,
  input  ahb_data_t  rdata,
  output uart_byte_t tx_byte,
  output logic       tx_start,
  input  logic       tx_done
);

  localparam byte_idx_t IDX_LAST = byte_idx_t'(`BRIDGE_WORD_BYTES - 1);

  typedef enum logic [2:0] {
    SEQ_IDLE,  // waiting for a command byte
    SEQ_ADDR,  // collecting address bytes
    SEQ_WDATA, // collecting write data bytes
    SEQ_BUS,   // transfer in flight
    SEQ_REPLY  // sending read data back
  } seq_state_e;

  seq_state_e state;
  byte_idx_t  idx;       // byte lane, shared by all phases
  logic       is_wr;     // frame is a write
  logic       req_start;
  ahb_addr_t  addr_q;
  ahb_data_t  wdata_q;
  ahb_data_t  rdata_q;
  logic       is_cmd;

  assign is_cmd  = (rx_byte == `BRIDGE_CMD_RD) || (rx_byte == `BRIDGE_CMD_WR);
  assign tx_byte = rdata_q[8*idx +: 8]; // lsb first
  assign req     = '{start: req_start, write: is_wr, addr: addr_q, wdata: wdata_q};

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state     <= SEQ_IDLE;
      idx       <= '0;
      is_wr     <= 1'b0;
      req_start <= 1'b0;
      tx_start  <= 1'b0;
    end else begin
      req_start <= 1'b0;
      tx_start  <= 1'b0;
      case (state)
        SEQ_IDLE:  if (rx_done && is_cmd) begin // anything else is dropped
          is_wr <= (rx_byte == `BRIDGE_CMD_WR);
          idx   <= '0;
          state <= SEQ_ADDR;
        end
        SEQ_ADDR:  if (rx_done) begin
          idx <= idx + 1'b1; // wraps to 0 for the data phase
          if (idx == IDX_LAST) begin
            if (is_wr) begin
              state <= SEQ_WDATA;
            end else begin
              state     <= SEQ_BUS;
              req_start <= 1'b1; // read needs no data
            end
          end
        end
        SEQ_WDATA: if (rx_done) begin
          idx <= idx + 1'b1;
          if (idx == IDX_LAST) begin
            state     <= SEQ_BUS;
            req_start <= 1'b1;
          end
        end
        SEQ_BUS:   if (done) begin
          idx <= '0;
          if (is_wr) begin
            state <= SEQ_IDLE; // writes send no reply
          end else begin
            state    <= SEQ_REPLY;
            tx_start <= 1'b1; // first reply byte
          end
        end
        SEQ_REPLY: if (tx_done) begin
          if (idx == IDX_LAST) begin
            state <= SEQ_IDLE;
          end else begin
            idx      <= idx + 1'b1;
            tx_start <= 1'b1;
          end
        end
        default:   state <= SEQ_IDLE;
      endcase
    end
  end

  // frame payload, little endian
  always_ff @(posedge HCLK) begin
    if (state == SEQ_ADDR && rx_done) addr_q[8*idx +: 8] <= rx_byte;
    if (state == SEQ_WDATA && rx_done) wdata_q[8*idx +: 8] <= rx_byte;
    if (state == SEQ_BUS && done && !is_wr) rdata_q <= rdata; // HRDATA only valid now
  end

endmodule

// ==== rtl/ahb_master.sv ====
`timescale 1ns/1ps

module ahb_master import ahb_pkg::*; (
  input  logic      HCLK,
  input  logic      HRESETn,
  input  bus_req_t  req,
  output logic      done,   // data phase accepted
  output ahb_data_t rdata,
  output ahb_mout_t mout,
  input  logic      HREADY,
  input  ahb_data_t HRDATA
);

  typedef enum logic [1:0] {
    M_IDLE,
    M_WAIT, // bus still busy, hold off the address phase
    M_ADDR,
    M_DATA
  } mst_state_e;

  mst_state_e state;
  ahb_addr_t  addr_q;
  ahb_data_t  wdata_q;
  logic       write_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= M_IDLE;
    end else begin
      case (state)
        M_IDLE:  if (req.start) state <= HREADY ? M_ADDR : M_WAIT;
        M_WAIT:  if (HREADY) state <= M_ADDR;
        M_ADDR:  if (HREADY) state <= M_DATA; // address accepted
        M_DATA:  if (HREADY) state <= M_IDLE; // slave done
        default: state <= M_IDLE;
      endcase
    end
  end

  // request held for the whole transfer
  always_ff @(posedge HCLK) begin
    if (state == M_IDLE && req.start) begin
      addr_q  <= req.addr;
      wdata_q <= req.wdata;
      write_q <= req.write;
    end
  end

  assign done  = (state == M_DATA) && HREADY;
  assign rdata = HRDATA;
  assign mout  = '{haddr:  addr_q,
                   htrans: (state == M_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE,
                   hwrite: (state == M_ADDR) && write_q,
                   hsize:  HSIZE_WORD,
                   hwdata: wdata_q}; // stays put through data phase waits

  a_addr_hold : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (state == M_ADDR && !HREADY) |=> $stable(mout.haddr) && $stable(mout.hwrite));

endmodule

// ==== rtl/uart_ahb_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_macros.svh"

module uart_ahb_bridge import uart_pkg::*, ahb_pkg::*; #(
  parameter int PRESCALE = `BRIDGE_PRESCALE
) (
  input  logic      HCLK,
  input  logic      HRESETn,
  input  logic      RX,
  output logic      TX,
  output ahb_mout_t mout,
  input  logic      HREADY,
  input  ahb_data_t HRDATA
);

  logic       tick;              // shared by rx and tx
  uart_byte_t rx_byte, tx_byte;
  logic       rx_done, tx_start, tx_done;
  bus_req_t   req;
  logic       done;
  ahb_data_t  rdata;

  baud_gen #(.PRESCALE(PRESCALE)) baud_gen_i (
    .HCLK(HCLK), .HRESETn(HRESETn), .tick(tick)
  );

  uart_rx uart_rx_i (
    .HCLK(HCLK), .HRESETn(HRESETn), .tick(tick), .rx(RX),
    .rx_byte(rx_byte), .rx_done(rx_done)
  );

  uart_tx uart_tx_i (
    .HCLK(HCLK), .HRESETn(HRESETn), .tick(tick), .tx_start(tx_start),
    .tx_byte(tx_byte), .tx_done(tx_done), .tx(TX)
  );

  cmd_seq cmd_seq_i (
    .HCLK(HCLK), .HRESETn(HRESETn), .rx_byte(rx_byte), .rx_done(rx_done),
    .req(req), .done(done), .rdata(rdata),
    .tx_byte(tx_byte), .tx_start(tx_start), .tx_done(tx_done)
  );

  ahb_master ahb_master_i (
    .HCLK(HCLK), .HRESETn(HRESETn), .req(req), .done(done), .rdata(rdata),
    .mout(mout), .HREADY(HREADY), .HRDATA(HRDATA)
  );

endmodule

// ==== sim/tb_uart_ahb_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_macros.svh"

module tb_uart_ahb_bridge
  import uart_pkg::*, ahb_pkg::*;
();

  localparam int N_PAT    = 12;      // lines in the pattern file
  localparam int BIT_CLKS = 32;      // PRESCALE 1 gives 16 ticks of 2 clocks
  // at most 9 frames of 10 bits per command plus half again
  localparam int TIMEOUT_CYCLES = N_PAT * 9 * 10 * BIT_CLKS * 3 / 2;

  logic       HCLK = 1'b0;
  logic       HRESETn;
  logic       RX;
  logic       TX;
  ahb_mout_t  mout;
  logic       HREADY = 1'b1;         // slave model drives these two
  ahb_data_t  HRDATA = '0;

  logic [71:0] pat_mem [N_PAT];      // op, addr, data
  uart_byte_t  tx_q[$];              // bytes decoded from TX
  int          xfer_cnt = 0;         // completed bus transfers
  int          cycle_cnt = 0;
  logic [31:0] rnd = 32'h297f_e732;  // wait state source
  logic        data_phase = 1'b0;

  // expected next transfer as set by the main process
  ahb_addr_t exp_addr;
  ahb_data_t exp_wdata;
  ahb_data_t exp_rdata;
  logic      exp_write;

  uart_ahb_bridge #(.PRESCALE(1)) uart_ahb_bridge_i (
    .HCLK(HCLK), .HRESETn(HRESETn), .RX(RX), .TX(TX), .mout(mout),
    .HREADY(HREADY), .HRDATA(HRDATA)
  );

  always #5 HCLK = ~HCLK; // 100 MHz

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_addr(input string name, input ahb_addr_t got, input ahb_addr_t exp);
    if (got !== exp) abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic check_data(input string name, input ahb_data_t got, input ahb_data_t exp);
    if (got !== exp) abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    if (got !== exp) abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic check_trans(input string name, input ahb_trans_t got, input ahb_trans_t exp);
    if (got !== exp) abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic check_size(input string name, input ahb_size_t got, input ahb_size_t exp);
    if (got !== exp) abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("ERR %s got %h exp %h", name, got, exp));
  endtask

  // one serial bit changed just after the edge
  task automatic drive_bit(input logic v);
    @(posedge HCLK);
    #1;
    RX = v;
    repeat (BIT_CLKS - 1) @(posedge HCLK);
  endtask

  task automatic send_byte(input uart_byte_t b);
    int k;
    drive_bit(1'b0); // start
    for (k = 0; k < 8; k++) drive_bit(b[k]); // lsb first
    drive_bit(1'b1); // stop
  endtask

  task automatic wait_xfers(input int n);
    while (xfer_cnt < n) @(negedge HCLK);
    if (xfer_cnt != n) abort_run($sformatf("saw %0d bus transfers, expected %0d", xfer_cnt, n));
  endtask

  // AHB slave model checks each transfer against the current frame
  always @(posedge HCLK) begin
    if (HRESETn) begin
      if (data_phase && HREADY) begin // data phase ends here
        if (exp_write) check_data("HWDATA", mout.hwdata, exp_wdata);
        xfer_cnt++;
        data_phase = 1'b0;
      end
      if (mout.htrans == HTRANS_NONSEQ && HREADY) begin // address accepted
        check_addr("HADDR", mout.haddr, exp_addr);
        check_flag("HWRITE", mout.hwrite, exp_write);
        check_size("HSIZE", mout.hsize, HSIZE_WORD);
        data_phase = 1'b1;
      end
    end
    rnd = xorshift32(rnd);
    #1;
    HREADY = !HRESETn || (rnd[1:0] != 2'b00); // about one wait in four
    HRDATA = (data_phase && !exp_write) ? exp_rdata : '0;
  end

  // serial monitor samples mid-bit on the falling clock
  initial begin : tx_monitor
    uart_byte_t b;
    int         k;
    wait (HRESETn === 1'b1);
    forever begin
      @(negedge HCLK);
      if (TX === 1'b0) begin
        repeat (BIT_CLKS / 2) @(negedge HCLK);
        if (TX !== 1'b0) abort_run("TX start bit ended early");
        for (k = 0; k < 8; k++) begin
          repeat (BIT_CLKS) @(negedge HCLK);
          b[k] = TX;
        end
        repeat (BIT_CLKS) @(negedge HCLK);
        if (TX !== 1'b1) abort_run("TX stop bit missing");
        tx_q.push_back(b);
      end
    end
  end

  always @(posedge HCLK) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      abort_run($sformatf("timeout, run still busy after %0d cycles", cycle_cnt));
  end

  initial begin
    int         i;
    int         j;
    int         n_exp;
    uart_byte_t op;
    ahb_addr_t  addr;
    ahb_data_t  data;
    uart_byte_t got;
    HRESETn   = 1'b0;
    RX        = 1'b1; // idle line
    exp_addr  = '0;
    exp_wdata = '0;
    exp_rdata = '0;
    exp_write = 1'b0;
    n_exp     = 0;
    $readmemh("sim/bridge_patterns.hex", pat_mem);
    repeat (4) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    @(negedge HCLK);
    check_flag("TX", TX, 1'b1);
    check_trans("HTRANS", mout.htrans, HTRANS_IDLE);

    for (i = 0; i < N_PAT; i++) begin
      op   = pat_mem[i][71:64];
      addr = pat_mem[i][63:32];
      data = pat_mem[i][31:0];
      if (tx_q.size() != 0) abort_run("TX sent bytes that no read asked for");
      if (op == `BRIDGE_CMD_WR || op == `BRIDGE_CMD_RD) begin
        exp_addr  = addr;
        exp_write = (op == `BRIDGE_CMD_WR);
        exp_wdata = data;
        exp_rdata = data; // slave returns the pattern word
        send_byte(op);
        for (j = 0; j < 4; j++) send_byte(addr[8*j +: 8]);
        if (exp_write) begin
          for (j = 0; j < 4; j++) send_byte(data[8*j +: 8]);
        end
        n_exp++;
        wait_xfers(n_exp);
        if (!exp_write) begin
          for (j = 0; j < 4; j++) begin // reply lsb first
            while (tx_q.size() == 0) @(negedge HCLK);
            got = tx_q.pop_front();
            check_byte($sformatf("TX byte %0d", j), got, data[8*j +: 8]);
          end
        end
      end else begin
        send_byte(op); // junk byte must be ignored
        repeat (2 * BIT_CLKS) @(posedge HCLK);
        if (xfer_cnt != n_exp) abort_run("junk command started a bus transfer");
      end
    end

    repeat (2 * BIT_CLKS) @(negedge HCLK);
    if (tx_q.size() != 0 || xfer_cnt != n_exp) begin
      abort_run("extra activity after the last command");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== sim/bridge_patterns.hex ====
// op_addr_data per line: op a3 write, a5 read, any other op is a junk command
// for a read the data column is the word the slave model returns
a3_00001000_deadbeef
a5_00001000_12345678
3c_00000000_00000000
a3_a5a3a5a3_a3a5a3a5
a5_a5a3a5a3_5aa55aa5
ff_00000000_00000000
a3_fffffffc_00000001
a5_00000000_80000000
a4_00000000_00000000
a3_40000010_0f1e2d3c
a5_40000010_ffffffff
a5_7654321c_00ff00ff

// ==== uart_ahb_bridge.f ====
+incdir+rtl
rtl/uart_pkg.sv
rtl/ahb_pkg.sv
rtl/baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/cmd_seq.sv
rtl/ahb_master.sv
rtl/uart_ahb_bridge.sv
sim/tb_uart_ahb_bridge.sv

// ==== Makefile ====
SRCS := $(shell grep '\.sv$$' uart_ahb_bridge.f)

obj_dir/Vtb_uart_ahb_bridge: uart_ahb_bridge.f $(SRCS) rtl/bridge_macros.svh
	verilator --binary --timing --assert -f uart_ahb_bridge.f --top-module tb_uart_ahb_bridge

run: obj_dir/Vtb_uart_ahb_bridge sim/bridge_patterns.hex
	./obj_dir/Vtb_uart_ahb_bridge

clean:
	rm -rf obj_dir

.PHONY: run clean
